/* rtl/exu_pkg.sv */
// shared widths, one-hot alu op bit positions and typedefs; import into every exu block
`default_nettype none

package exu_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int REG_DATA_WIDTH  = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int REG_NUM         = 32;
    localparam int COMMIT_ID_WIDTH = 3;
    localparam int ALU_OP_WIDTH    = 13;
    // shift amount field of op2
    localparam int SHAMT_WIDTH     = 5;

    // return address offset for jal/jalr
    localparam logic [REG_DATA_WIDTH-1:0] JUMP_LINK_OFFSET = 32'd4;

    //////////////////////////////////////////////////
    // one-hot operation bit indices
    //////////////////////////////////////////////////
    localparam int ALU_OP_ADD   = 0;
    localparam int ALU_OP_SUB   = 1;
    localparam int ALU_OP_SLL   = 2;
    localparam int ALU_OP_SLT   = 3;
    localparam int ALU_OP_SLTU  = 4;
    localparam int ALU_OP_XOR   = 5;
    localparam int ALU_OP_SRL   = 6;
    localparam int ALU_OP_SRA   = 7;
    localparam int ALU_OP_OR    = 8;
    localparam int ALU_OP_AND   = 9;
    localparam int ALU_OP_LUI   = 10;
    localparam int ALU_OP_AUIPC = 11;
    localparam int ALU_OP_JUMP  = 12;

    // payload types
    typedef logic [REG_DATA_WIDTH-1:0]  reg_data_t;
    typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [COMMIT_ID_WIDTH-1:0] commit_id_t;
    typedef logic [ALU_OP_WIDTH-1:0]    alu_op_t;

endpackage

`default_nettype wire

/* rtl/gnrl_dfflr.sv */
// generic load-enable flop with sync reset to zero; set T to the payload type it holds
`timescale 1ns/10ps
`default_nettype none

module gnrl_dfflr #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_i,
    input  logic lden_i,
    input  T     dnxt_i,
    output T     qout_o
);

    // clear on reset, else take dnxt when enabled
    always_ff @(posedge clk) begin
        if (rst_i) begin
            qout_o <= '0;
        end else if (lden_i) begin
            qout_o <= dnxt_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/exu_regfile.sv */
// integer register file, 2 async read ports and 1 sync write port, x0 hardwired to zero
`timescale 1ns/10ps
`default_nettype none

module exu_regfile (
    input  logic               clk,
    input  logic               rst_i,
    input  exu_pkg::reg_addr_t raddr1_i,
    input  exu_pkg::reg_addr_t raddr2_i,
    output exu_pkg::reg_data_t rdata1_o,
    output exu_pkg::reg_data_t rdata2_o,
    input  logic               we_i,
    input  exu_pkg::reg_addr_t waddr_i,
    input  exu_pkg::reg_data_t wdata_i
);

    import exu_pkg::*;

    // entry 0 stays at its reset value
    reg_data_t regs_q [REG_NUM];

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            // writes to x0 dropped
            regs_q[waddr_i] <= wdata_i;
        end
    end

    //////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////
    // no write bypass, same-edge read sees old value
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

/* rtl/exu_opsel.sv */
// alu operand mux: forwards the pending output-stage result and picks pc, imm or 4
`timescale 1ns/10ps
`default_nettype none

module exu_opsel (
    input  exu_pkg::reg_addr_t rs1_i,
    input  exu_pkg::reg_addr_t rs2_i,
    input  exu_pkg::reg_data_t rdata1_i,
    input  exu_pkg::reg_data_t rdata2_i,
    input  exu_pkg::reg_data_t imm_i,
    input  exu_pkg::reg_data_t pc_i,
    input  logic               use_imm_i,
    input  exu_pkg::alu_op_t   alu_op_info_i,
    input  logic               fwd_we_i,
    input  exu_pkg::reg_addr_t fwd_addr_i,
    input  exu_pkg::reg_data_t fwd_data_i,
    output exu_pkg::reg_data_t alu_op1_o,
    output exu_pkg::reg_data_t alu_op2_o
);

    import exu_pkg::*;

    // forward hit per source, never for x0
    logic fwd_hit1;
    logic fwd_hit2;
    assign fwd_hit1 = fwd_we_i && (rs1_i != '0) && (rs1_i == fwd_addr_i);
    assign fwd_hit2 = fwd_we_i && (rs2_i != '0) && (rs2_i == fwd_addr_i);

    // resolved register values
    reg_data_t rs1_val;
    reg_data_t rs2_val;
    assign rs1_val = fwd_hit1 ? fwd_data_i : rdata1_i;
    assign rs2_val = fwd_hit2 ? fwd_data_i : rdata2_i;

    // op1: pc for auipc / jump
    logic pc_as_op1;
    assign pc_as_op1 = alu_op_info_i[ALU_OP_AUIPC] | alu_op_info_i[ALU_OP_JUMP];
    assign alu_op1_o = pc_as_op1 ? pc_i : rs1_val;

    // op2: link offset for jump, imm for i-type, lui, auipc
    logic imm_as_op2;
    assign imm_as_op2 = use_imm_i | alu_op_info_i[ALU_OP_LUI] | alu_op_info_i[ALU_OP_AUIPC];
    assign alu_op2_o  = alu_op_info_i[ALU_OP_JUMP] ? JUMP_LINK_OFFSET :
                        imm_as_op2                 ? imm_i : rs2_val;

endmodule

`default_nettype wire

/* rtl/exu_alu.sv */
// shared-datapath integer alu with one registered output stage under wb_ready back-pressure
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 req_alu_i,
    input  exu_pkg::reg_data_t   alu_op1_i,
    input  exu_pkg::reg_data_t   alu_op2_i,
    input  exu_pkg::alu_op_t     alu_op_info_i,
    input  exu_pkg::reg_addr_t   alu_rd_i,
    input  exu_pkg::commit_id_t  commit_id_i,
    input  logic                 reg_we_i,
    input  logic                 wb_ready_i,
    input  logic                 int_assert_i,
    output logic                 alu_stall_o,
    output exu_pkg::reg_data_t   result_o,
    output logic                 reg_we_o,
    output exu_pkg::reg_addr_t   reg_waddr_o,
    output exu_pkg::commit_id_t  commit_id_o
);

    import exu_pkg::*;

    // mirror a word end to end
    function automatic reg_data_t bit_rev(input reg_data_t v);
        reg_data_t r;
        for (int i = 0; i < REG_DATA_WIDTH; i++) begin
            r[i] = v[REG_DATA_WIDTH-1-i];
        end
        return r;
    endfunction

    // op decode
    logic op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl;
    logic op_sra, op_or, op_and, op_lui, op_auipc, op_jump;
    assign op_add   = alu_op_info_i[ALU_OP_ADD];
    assign op_sub   = alu_op_info_i[ALU_OP_SUB];
    assign op_sll   = alu_op_info_i[ALU_OP_SLL];
    assign op_slt   = alu_op_info_i[ALU_OP_SLT];
    assign op_sltu  = alu_op_info_i[ALU_OP_SLTU];
    assign op_xor   = alu_op_info_i[ALU_OP_XOR];
    assign op_srl   = alu_op_info_i[ALU_OP_SRL];
    assign op_sra   = alu_op_info_i[ALU_OP_SRA];
    assign op_or    = alu_op_info_i[ALU_OP_OR];
    assign op_and   = alu_op_info_i[ALU_OP_AND];
    assign op_lui   = alu_op_info_i[ALU_OP_LUI];
    assign op_auipc = alu_op_info_i[ALU_OP_AUIPC];
    assign op_jump  = alu_op_info_i[ALU_OP_JUMP];

    //////////////////////////////////////////////////
    // shifter, left only
    //////////////////////////////////////////////////
    // right shifts go through mirrored in and out
    logic                   op_right;
    logic [SHAMT_WIDTH-1:0] shamt;
    reg_data_t              shifter_in;
    reg_data_t              shifter_res;
    reg_data_t              srl_res;
    reg_data_t              shift_mask;
    reg_data_t              sra_res;
    assign op_right    = op_srl | op_sra;
    assign shamt       = alu_op2_i[SHAMT_WIDTH-1:0];
    assign shifter_in  = op_right ? bit_rev(alu_op1_i) : alu_op1_i;
    assign shifter_res = shifter_in << shamt;
    assign srl_res     = bit_rev(shifter_res);
    // vacated top bits, refilled with op1 sign
    assign shift_mask  = ~({REG_DATA_WIDTH{1'b1}} >> shamt);
    assign sra_res     = (srl_res & ~shift_mask) | ({REG_DATA_WIDTH{alu_op1_i[31]}} & shift_mask);

    //////////////////////////////////////////////////
    // shared 33-bit adder
    //////////////////////////////////////////////////
    // sub and compares: op1 + ~op2 + 1
    logic                    adder_inv;
    reg_data_t               adder_in2;
    logic [REG_DATA_WIDTH:0] adder_res;
    assign adder_inv = op_sub | op_slt | op_sltu;
    assign adder_in2 = adder_inv ? ~alu_op2_i : alu_op2_i;
    assign adder_res = {1'b0, alu_op1_i} + {1'b0, adder_in2} + {{REG_DATA_WIDTH{1'b0}}, adder_inv};

    // signed lt: sign of op1 if signs differ, else sign of difference
    logic lt_signed;
    logic lt_unsigned;
    assign lt_signed   = (alu_op1_i[31] != alu_op2_i[31]) ? alu_op1_i[31] : adder_res[31];
    // no carry out means a borrow
    assign lt_unsigned = ~adder_res[REG_DATA_WIDTH];

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////
    // and-or mux, op vector is one-hot
    reg_data_t alu_res;
    assign alu_res =
        ({REG_DATA_WIDTH{op_add | op_sub | op_auipc | op_jump}} & adder_res[REG_DATA_WIDTH-1:0]) |
        ({REG_DATA_WIDTH{op_sll}}  & shifter_res) |
        ({REG_DATA_WIDTH{op_srl}}  & srl_res) |
        ({REG_DATA_WIDTH{op_sra}}  & sra_res) |
        ({REG_DATA_WIDTH{op_xor}}  & (alu_op1_i ^ alu_op2_i)) |
        ({REG_DATA_WIDTH{op_or}}   & (alu_op1_i | alu_op2_i)) |
        ({REG_DATA_WIDTH{op_and}}  & (alu_op1_i & alu_op2_i)) |
        ({REG_DATA_WIDTH{op_slt}}  & {{(REG_DATA_WIDTH-1){1'b0}}, lt_signed}) |
        ({REG_DATA_WIDTH{op_sltu}} & {{(REG_DATA_WIDTH-1){1'b0}}, lt_unsigned}) |
        ({REG_DATA_WIDTH{op_lui}}  & alu_op2_i);

    // empty or flushed slot: zero result, no write
    logic      issue_ok;
    reg_data_t res_nxt;
    logic      we_nxt;
    reg_addr_t waddr_nxt;
    assign issue_ok  = req_alu_i & ~int_assert_i;
    assign res_nxt   = issue_ok ? alu_res : '0;
    assign we_nxt    = issue_ok & reg_we_i;
    assign waddr_nxt = issue_ok ? alu_rd_i : '0;

    //////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////
    // load when empty or being drained this edge
    logic update_output;
    assign update_output = wb_ready_i | ~reg_we_o;
    assign alu_stall_o   = reg_we_o & ~wb_ready_i;

    gnrl_dfflr #(.T(reg_data_t)) u_result_dfflr (
        .clk(clk), .rst_i(rst_i), .lden_i(update_output), .dnxt_i(res_nxt), .qout_o(result_o)
    );
    gnrl_dfflr #(.T(logic)) u_we_dfflr (
        .clk(clk), .rst_i(rst_i), .lden_i(update_output), .dnxt_i(we_nxt), .qout_o(reg_we_o)
    );
    gnrl_dfflr #(.T(reg_addr_t)) u_waddr_dfflr (
        .clk(clk), .rst_i(rst_i), .lden_i(update_output), .dnxt_i(waddr_nxt),
        .qout_o(reg_waddr_o)
    );
    gnrl_dfflr #(.T(commit_id_t)) u_commit_id_dfflr (
        .clk(clk), .rst_i(rst_i), .lden_i(update_output), .dnxt_i(commit_id_i),
        .qout_o(commit_id_o)
    );

endmodule

`default_nettype wire

/* rtl/exu_top.sv */
// execute slice top: regfile, operand select and alu; writeback on wb_ready acceptance
`timescale 1ns/10ps
`default_nettype none

module exu_top (
    input  logic                 clk,
    input  logic                 rst_i,
    // issue side
    input  logic                 req_alu_i,
    input  exu_pkg::reg_addr_t   rs1_i,
    input  exu_pkg::reg_addr_t   rs2_i,
    input  exu_pkg::reg_data_t   imm_i,
    input  exu_pkg::reg_data_t   pc_i,
    input  logic                 use_imm_i,
    input  exu_pkg::alu_op_t     alu_op_info_i,
    input  exu_pkg::reg_addr_t   rd_i,
    input  exu_pkg::commit_id_t  commit_id_i,
    input  logic                 reg_we_i,
    // writeback and interrupt control
    input  logic                 wb_ready_i,
    input  logic                 int_assert_i,
    output logic                 alu_stall_o,
    output exu_pkg::reg_data_t   result_o,
    output logic                 reg_we_o,
    output exu_pkg::reg_addr_t   reg_waddr_o,
    output exu_pkg::commit_id_t  commit_id_o
);

    import exu_pkg::*;

    reg_data_t rdata1;
    reg_data_t rdata2;
    reg_data_t alu_op1;
    reg_data_t alu_op2;

    // commit on the accepting edge
    logic rf_we;
    assign rf_we = reg_we_o & wb_ready_i;

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////
    exu_regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddr1_i (rs1_i),
        .raddr2_i (rs2_i),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (rf_we),
        .waddr_i  (reg_waddr_o),
        .wdata_i  (result_o)
    );

    // forward source is the pending output-stage entry
    exu_opsel u_opsel (
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .imm_i         (imm_i),
        .pc_i          (pc_i),
        .use_imm_i     (use_imm_i),
        .alu_op_info_i (alu_op_info_i),
        .fwd_we_i      (reg_we_o),
        .fwd_addr_i    (reg_waddr_o),
        .fwd_data_i    (result_o),
        .alu_op1_o     (alu_op1),
        .alu_op2_o     (alu_op2)
    );

    exu_alu u_alu (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_alu_i     (req_alu_i),
        .alu_op1_i     (alu_op1),
        .alu_op2_i     (alu_op2),
        .alu_op_info_i (alu_op_info_i),
        .alu_rd_i      (rd_i),
        .commit_id_i   (commit_id_i),
        .reg_we_i      (reg_we_i),
        .wb_ready_i    (wb_ready_i),
        .int_assert_i  (int_assert_i),
        .alu_stall_o   (alu_stall_o),
        .result_o      (result_o),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .commit_id_o   (commit_id_o)
    );

endmodule

`default_nettype wire

/* tests/exu_sva.sv */
// concurrent checks on the exu output stage, bound into every exu_top instance
`timescale 1ns/10ps
`default_nettype none

module exu_sva (
    input logic                clk,
    input logic                rst_i,
    input logic                req_alu_i,
    input logic                reg_we_i,
    input logic                int_assert_i,
    input exu_pkg::reg_addr_t  rd_i,
    input logic                alu_stall_o,
    input exu_pkg::reg_data_t  result_o,
    input logic                reg_we_o,
    input exu_pkg::reg_addr_t  reg_waddr_o,
    input exu_pkg::commit_id_t commit_id_o
);

    // stall only while holding a write taken without flush
    stall_needs_we: assert property (@(posedge clk) disable iff (rst_i)
        alu_stall_o |-> ($past(alu_stall_o) ||
                         $past(req_alu_i && reg_we_i && !int_assert_i)))
        else $error("alu_stall_o high without a pending unflushed write");

    // output stage frozen under back-pressure
    stall_holds_outputs: assert property (@(posedge clk) disable iff (rst_i)
        alu_stall_o |=> ($stable(result_o) && $stable(reg_we_o) &&
                         $stable(reg_waddr_o) && $stable(commit_id_o)))
        else $error("output stage changed during a stall");

    // a taken writing instruction with nonzero rd keeps its address
    waddr_nonzero: assert property (@(posedge clk) disable iff (rst_i)
        (req_alu_i && !alu_stall_o && !int_assert_i && reg_we_i && (rd_i != '0))
        |=> (reg_we_o && (reg_waddr_o != '0)))
        else $error("reg_waddr_o zero for an instruction with nonzero rd");

endmodule

bind exu_top exu_sva sva_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_alu_i    (req_alu_i),
    .reg_we_i     (reg_we_i),
    .int_assert_i (int_assert_i),
    .rd_i         (rd_i),
    .alu_stall_o  (alu_stall_o),
    .result_o     (result_o),
    .reg_we_o     (reg_we_o),
    .reg_waddr_o  (reg_waddr_o),
    .commit_id_o  (commit_id_o)
);

`default_nettype wire

/* tests/tb_exu.sv */
// self-checking testbench for exu_top; lcg stimulus, reference model, timeout and final verdict
`timescale 1ns/10ps
`default_nettype none

module tb_exu;

    import exu_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int N_RANDOM       = 400;
    localparam int N_UPPER        = 60;
    localparam int N_BACKP        = 200;
    localparam int N_FWD          = 120;
    localparam int N_FLUSH        = 60;
    // two register sweeps on top of the random tests
    localparam int N_TOTAL        = 2 * REG_NUM + N_RANDOM + N_UPPER + N_BACKP + N_FWD + N_FLUSH;
    localparam int TIMEOUT_CYCLES = 20 * N_TOTAL;

    // expected output stage contents
    typedef struct packed {
        reg_data_t  res;
        logic       we;
        reg_addr_t  addr;
        commit_id_t id;
    } out_t;

    logic       clk = 1'b0;
    logic       rst_i;
    logic       req_alu_i;
    reg_addr_t  rs1_i;
    reg_addr_t  rs2_i;
    reg_data_t  imm_i;
    reg_data_t  pc_i;
    logic       use_imm_i;
    alu_op_t    alu_op_info_i;
    reg_addr_t  rd_i;
    commit_id_t commit_id_i;
    logic       reg_we_i;
    logic       wb_ready_i;
    logic       int_assert_i;
    logic       alu_stall_o;
    reg_data_t  result_o;
    logic       reg_we_o;
    reg_addr_t  reg_waddr_o;
    commit_id_t commit_id_o;

    // model state
    reg_data_t   model_regs [REG_NUM];
    out_t        out_e;
    commit_id_t  id_q [$];
    logic [31:0] lcg_state = 32'hb6f99544;
    int          cur_op = 0;
    logic        taken = 1'b0;
    logic        ready_random = 1'b0;
    int          issue_cnt = 0;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;
    int          test_err_base = 0;

    exu_top dut_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_alu_i     (req_alu_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .imm_i         (imm_i),
        .pc_i          (pc_i),
        .use_imm_i     (use_imm_i),
        .alu_op_info_i (alu_op_info_i),
        .rd_i          (rd_i),
        .commit_id_i   (commit_id_i),
        .reg_we_i      (reg_we_i),
        .wb_ready_i    (wb_ready_i),
        .int_assert_i  (int_assert_i),
        .alu_stall_o   (alu_stall_o),
        .result_o      (result_o),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .commit_id_o   (commit_id_o)
    );

    always #5 clk = ~clk;

    // watchdog
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // random numbers
    //////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only, low lcg bits are weak
    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] v;
        v = lcg_next();
        return (v >> 8) % n;
    endfunction

    function automatic reg_data_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    // rv32i semantics per operation
    function automatic reg_data_t ref_alu(input int op, input reg_data_t a, input reg_data_t b);
        case (op)
            ALU_OP_ADD, ALU_OP_AUIPC, ALU_OP_JUMP: return a + b;
            ALU_OP_SUB:  return a - b;
            ALU_OP_SLL:  return a << b[4:0];
            ALU_OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_OP_XOR:  return a ^ b;
            ALU_OP_SRL:  return a >> b[4:0];
            ALU_OP_SRA:  return $signed(a) >>> b[4:0];
            ALU_OP_OR:   return a | b;
            ALU_OP_AND:  return a & b;
            ALU_OP_LUI:  return b;
            default:     return '0;
        endcase
    endfunction

    // latest value in program order, a pending result is newer than the regfile
    function automatic reg_data_t arch_reg(input reg_addr_t r);
        if (r == '0) begin
            return '0;
        end
        if (out_e.we && (out_e.addr == r)) begin
            return out_e.res;
        end
        return model_regs[r];
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input commit_id_t got, input commit_id_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // compare at negedge, then step the model across the coming edge
    task automatic observe();
        out_t       nxt;
        reg_data_t  op1;
        reg_data_t  op2;
        logic       accept;
        logic       load;
        commit_id_t exp_id;
        check_bit("reg_we_o", reg_we_o, out_e.we);
        check_bit("alu_stall_o", alu_stall_o, out_e.we & ~wb_ready_i);
        check_data("result_o", result_o, out_e.res);
        check_addr("reg_waddr_o", reg_waddr_o, out_e.addr);
        check_id("commit_id_o", commit_id_o, out_e.id);
        accept = out_e.we & wb_ready_i;
        load   = wb_ready_i | ~out_e.we;
        taken  = req_alu_i & load;
        // empty or flushed slot loads zeros
        nxt    = '0;
        nxt.id = commit_id_i;
        if (req_alu_i && !int_assert_i) begin
            op1 = (cur_op == ALU_OP_AUIPC || cur_op == ALU_OP_JUMP) ? pc_i : arch_reg(rs1_i);
            if (cur_op == ALU_OP_JUMP) begin
                op2 = 32'd4;
            end else if (use_imm_i || cur_op == ALU_OP_LUI || cur_op == ALU_OP_AUIPC) begin
                op2 = imm_i;
            end else begin
                op2 = arch_reg(rs2_i);
            end
            nxt.res  = ref_alu(cur_op, op1, op2);
            nxt.we   = reg_we_i;
            nxt.addr = rd_i;
        end
        if (accept) begin
            if (id_q.size() == 0) begin
                err_cnt++;
                $display("result accepted at %0t with no instruction outstanding", $time);
            end else begin
                exp_id = id_q.pop_front();
                check_id("commit_id_o order", commit_id_o, exp_id);
            end
            if (out_e.addr != '0) begin
                model_regs[out_e.addr] = out_e.res;
            end
        end
        if (load) begin
            if (taken && nxt.we) begin
                id_q.push_back(nxt.id);
            end
            out_e = nxt;
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic tick();
        @(negedge clk);
        observe();
        @(posedge clk);
        wb_ready_i <= ready_random ? (rand_below(2) == 1) : 1'b1;
    endtask

    task automatic send_instr(input int op, input reg_addr_t rs1, input reg_addr_t rs2,
                              input reg_addr_t rd, input reg_data_t imm, input reg_data_t pc,
                              input logic use_imm, input logic flush);
        req_alu_i     <= 1'b1;
        rs1_i         <= rs1;
        rs2_i         <= rs2;
        imm_i         <= imm;
        pc_i          <= pc;
        use_imm_i     <= use_imm;
        alu_op_info_i <= alu_op_t'(1) << op;
        rd_i          <= rd;
        commit_id_i   <= commit_id_t'(issue_cnt);
        reg_we_i      <= 1'b1;
        int_assert_i  <= flush;
        cur_op    = op;
        issue_cnt = issue_cnt + 1;
        // fields held until an edge takes them
        taken = 1'b0;
        while (!taken) begin
            tick();
        end
    endtask

    task automatic random_instr(input int op_lo, input int op_hi, input logic flush);
        int        op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        reg_data_t imm;
        reg_data_t pc;
        logic      use_imm;
        op = op_lo + int'(rand_below(op_hi - op_lo + 1));
        // shift by 0 and 31, sign-boundary compares
        case (rand_below(4))
            0:       imm = '0;
            1:       imm = 32'd31;
            2:       imm = 32'h8000_0000;
            default: imm = rand_word();
        endcase
        rs1     = reg_addr_t'(rand_below(32));
        rs2     = reg_addr_t'(rand_below(32));
        rd      = (rand_below(16) == 0) ? '0 : reg_addr_t'(1 + rand_below(31));
        pc      = rand_word() & 32'hffff_fffc;
        use_imm = (rand_below(2) == 1);
        send_instr(op, rs1, rs2, rd, imm, pc, use_imm, flush);
    endtask

    // add rk + x0 into x0 for every register
    task automatic read_all_regs();
        for (int k = 0; k < REG_NUM; k++) begin
            send_instr(ALU_OP_ADD, reg_addr_t'(k), '0, '0, '0, '0, 1'b0, 1'b0);
        end
    endtask

    task automatic drain();
        req_alu_i    <= 1'b0;
        int_assert_i <= 1'b0;
        tick();
        while (id_q.size() != 0) begin
            tick();
        end
    endtask

    task automatic finish_test(input string name, input int n_instr);
        test_cnt++;
        $display("test %s: %0d instructions, %0d errors", name, n_instr,
                 err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic test_forwarding();
        reg_addr_t   prev_rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        int unsigned sel;
        int          op;
        prev_rd      = 5'd1;
        ready_random = 1'b1;
        for (int i = 0; i < N_FWD; i++) begin
            // one or both sources hit the previous rd, rd sometimes x0
            sel = rand_below(3);
            rs1 = (sel != 1) ? prev_rd : reg_addr_t'(rand_below(32));
            rs2 = (sel != 0) ? prev_rd : reg_addr_t'(rand_below(32));
            rd  = (rand_below(8) == 0) ? '0 : reg_addr_t'(1 + rand_below(31));
            op  = int'(rand_below(ALU_OP_AND + 1));
            send_instr(op, rs1, rs2, rd, rand_word(), '0, 1'b0, 1'b0);
            prev_rd = rd;
        end
        drain();
        ready_random = 1'b0;
        finish_test("forwarding", N_FWD);
    endtask

    initial begin
        rst_i         <= 1'b1;
        req_alu_i     <= 1'b0;
        rs1_i         <= '0;
        rs2_i         <= '0;
        imm_i         <= '0;
        pc_i          <= '0;
        use_imm_i     <= 1'b0;
        alu_op_info_i <= '0;
        rd_i          <= '0;
        commit_id_i   <= '0;
        reg_we_i      <= 1'b0;
        wb_ready_i    <= 1'b1;
        int_assert_i  <= 1'b0;
        out_e = '0;
        for (int k = 0; k < REG_NUM; k++) begin
            model_regs[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;

        // first idle tick checks the reset outputs
        tick();
        read_all_regs();
        drain();
        finish_test("reset", REG_NUM);

        for (int i = 0; i < N_RANDOM; i++) begin
            random_instr(ALU_OP_ADD, ALU_OP_AND, 1'b0);
        end
        drain();
        finish_test("random_ops", N_RANDOM);

        for (int i = 0; i < N_UPPER; i++) begin
            random_instr(ALU_OP_LUI, ALU_OP_JUMP, 1'b0);
        end
        drain();
        finish_test("lui_auipc_jump", N_UPPER);

        ready_random = 1'b1;
        for (int i = 0; i < N_BACKP; i++) begin
            random_instr(ALU_OP_ADD, ALU_OP_JUMP, 1'b0);
        end
        drain();
        ready_random = 1'b0;
        finish_test("back_pressure", N_BACKP);

        test_forwarding();

        // flushed writes must leave the registers alone
        for (int i = 0; i < N_FLUSH; i++) begin
            random_instr(ALU_OP_ADD, ALU_OP_JUMP, rand_below(2) == 1);
        end
        drain();
        read_all_regs();
        drain();
        finish_test("flush", N_FLUSH + REG_NUM);

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/exu_pkg.sv
rtl/gnrl_dfflr.sv
rtl/exu_regfile.sv
rtl/exu_opsel.sv
rtl/exu_alu.sv
rtl/exu_top.sv
tests/exu_sva.sv
tests/tb_exu.sv

/* run.sh */
#!/bin/sh
# Build the exu testbench with Verilator, run it, and decide the result from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_exu -Mdir obj_dir -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# raise the error limit so that assertion failures do not stop the run early
./obj_dir/Vtb_exu +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
